/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    // memory geometry, 2 Kbyte part
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // fixed upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // bus primitives issued to the bit engine
    localparam logic [1:0] BIT_START = 2'd0;
    localparam logic [1:0] BIT_STOP  = 2'd1;
    localparam logic [1:0] BIT_WRITE = 2'd2;
    localparam logic [1:0] BIT_READ  = 2'd3;

    // control byte: assembled by fields, shifted out as a raw byte
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] device;
            logic [2:0] block;  // addr[10:8]
            logic       rw;     // 1 = read
        } fields;
    } ctrl_byte_u;

endpackage

/* hdl/eeprom_cmd_regs.sv */
module eeprom_cmd_regs (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            wr,
    input  logic                            rd,
    input  logic [eeprom_pkg::ADDR_W-1:0]   addr,
    input  logic [eeprom_pkg::DATA_W-1:0]   wdata,
    input  logic                            done_pulse,
    input  logic [eeprom_pkg::DATA_W-1:0]   read_byte,
    input  logic                            nack_flag,
    output logic                            start,
    output logic                            op_read,
    output logic [eeprom_pkg::ADDR_W-1:0]   cmd_addr,
    output logic [eeprom_pkg::DATA_W-1:0]   cmd_wdata,
    output logic                            busy,
    output logic                            done,
    output logic                            nack,
    output logic [eeprom_pkg::DATA_W-1:0]   rdata
);

    logic accept;

    // strobes while busy are dropped
    assign accept = !busy && (wr || rd);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
            nack  <= 1'b0;
        end
        else
        begin
            start <= accept;
            done  <= done_pulse;    // falls together with busy
            if (accept)
            begin
                busy <= 1'b1;
            end
            else if (done_pulse)
            begin
                busy <= 1'b0;
                nack <= nack_flag;
            end
        end
    end

    // request held for the whole transaction, result until the next one
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op_read   <= !wr;   // wr wins over rd
            cmd_addr  <= addr;
            cmd_wdata <= wdata;
        end
        if (done_pulse && op_read && !nack_flag)
        begin
            rdata <= read_byte;
        end
    end

endmodule

/* hdl/i2c_bit_engine.sv */
module i2c_bit_engine #(
    parameter int CLK_DIV = 2
) (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            go,
    input  logic [1:0]                      bit_cmd,
    input  logic [eeprom_pkg::DATA_W-1:0]   tx_byte,
    input  logic                            sda_in,
    output logic                            bit_done,
    output logic                            ack_ok,
    output logic [eeprom_pkg::DATA_W-1:0]   rx_byte,
    output logic                            scl,
    output logic                            sda_oe
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);
    localparam logic [3:0] ACK_PERIOD = 4'(eeprom_pkg::DATA_W);

    logic                           active;
    logic                           high_ph;    // second half of an scl period
    logic [CNT_W-1:0]               cnt;
    logic [3:0]                     period;
    logic [1:0]                     cmd;
    logic [eeprom_pkg::DATA_W-1:0]  shreg;
    logic                           master_nack;
    logic                           byte_cmd;
    logic                           last_period;
    logic                           phase_first;
    logic                           phase_end;
    logic                           oe_next;

    assign byte_cmd    = (cmd == eeprom_pkg::BIT_WRITE) || (cmd == eeprom_pkg::BIT_READ);
    assign last_period = byte_cmd ? (period == ACK_PERIOD) : (period == 4'd0);
    assign phase_first = active && (cnt == '0);
    assign phase_end   = active && (cnt == CNT_LAST);

    // high when idle, between primitives too
    assign scl     = !active || high_ph;
    assign rx_byte = shreg;

    // sda level applied after the first cycle of each phase
    always_comb
    begin
        oe_next = sda_oe;
        case (cmd)
            eeprom_pkg::BIT_START:
                oe_next = high_ph;      // falls while scl high
            eeprom_pkg::BIT_STOP:
                oe_next = !high_ph;     // rises while scl high
            eeprom_pkg::BIT_WRITE:
            begin
                if (!high_ph)
                begin
                    oe_next = (period == ACK_PERIOD) ? 1'b0 : !shreg[eeprom_pkg::DATA_W-1];
                end
            end
            eeprom_pkg::BIT_READ:
            begin
                if (!high_ph)
                begin
                    oe_next = (period == ACK_PERIOD) ? !master_nack : 1'b0;
                end
            end
            default:
                oe_next = sda_oe;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            high_ph  <= 1'b0;
            cnt      <= '0;
            period   <= '0;
            cmd      <= eeprom_pkg::BIT_STOP;
            sda_oe   <= 1'b0;
            bit_done <= 1'b0;
            ack_ok   <= 1'b0;
        end
        else
        begin
            bit_done <= 1'b0;
            if (!active)
            begin
                if (go)
                begin
                    active  <= 1'b1;
                    high_ph <= 1'b0;    // scl drops now
                    cnt     <= '0;
                    period  <= '0;
                    cmd     <= bit_cmd;
                end
            end
            else
            begin
                cnt <= phase_end ? '0 : cnt + 1'b1;
                if (phase_first)
                begin
                    sda_oe <= oe_next;
                end
                // ninth clock of a byte out
                if (phase_first && high_ph && cmd == eeprom_pkg::BIT_WRITE &&
                    period == ACK_PERIOD)
                begin
                    ack_ok <= !sda_in;
                end
                if (phase_end)
                begin
                    if (!high_ph)
                    begin
                        high_ph <= 1'b1;
                    end
                    else if (last_period)
                    begin
                        active   <= 1'b0;
                        bit_done <= 1'b1;
                    end
                    else
                    begin
                        high_ph <= 1'b0;
                        period  <= period + 1'b1;
                    end
                end
            end
        end
    end

    // shift register, MSB first both ways
    always_ff @(posedge CLK)
    begin
        if (go && !active)
        begin
            shreg       <= tx_byte;
            master_nack <= tx_byte[0];
        end
        else if (phase_first && period != ACK_PERIOD)
        begin
            if (cmd == eeprom_pkg::BIT_WRITE && !high_ph)
            begin
                shreg <= {shreg[eeprom_pkg::DATA_W-2:0], 1'b0};
            end
            else if (cmd == eeprom_pkg::BIT_READ && high_ph)
            begin
                shreg <= {shreg[eeprom_pkg::DATA_W-2:0], sda_in};   // sample at scl high
            end
        end
    end

endmodule

/* hdl/eeprom_sequencer.sv */
module eeprom_sequencer (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            start,
    input  logic                            op_read,
    input  logic [eeprom_pkg::ADDR_W-1:0]   cmd_addr,
    input  logic [eeprom_pkg::DATA_W-1:0]   cmd_wdata,
    input  logic                            bit_done,
    input  logic                            ack_ok,
    input  logic [eeprom_pkg::DATA_W-1:0]   rx_byte,
    output logic                            go,
    output logic [1:0]                      bit_cmd,
    output logic [eeprom_pkg::DATA_W-1:0]   tx_byte,
    output logic                            done_pulse,
    output logic [eeprom_pkg::DATA_W-1:0]   read_byte,
    output logic                            nack_flag
);

    localparam logic [3:0] S_IDLE   = 4'd0;
    localparam logic [3:0] S_START  = 4'd1;
    localparam logic [3:0] S_CTRL_W = 4'd2;
    localparam logic [3:0] S_ADDR   = 4'd3;
    localparam logic [3:0] S_DATA_W = 4'd4;
    localparam logic [3:0] S_RSTART = 4'd5;
    localparam logic [3:0] S_CTRL_R = 4'd6;
    localparam logic [3:0] S_DATA_R = 4'd7;
    localparam logic [3:0] S_STOP   = 4'd8;

    // read byte ends with not-acknowledge
    localparam logic [eeprom_pkg::DATA_W-1:0] MASTER_NACK = {{(eeprom_pkg::DATA_W-1){1'b0}}, 1'b1};

    logic [3:0]             state;
    logic                   byte_out;
    eeprom_pkg::ctrl_byte_u ctrl;

    // rw bit set only when leaving the repeated start
    always_comb
    begin
        ctrl.fields.device = eeprom_pkg::DEVICE_CODE;
        ctrl.fields.block  = cmd_addr[eeprom_pkg::ADDR_W-1:8];
        ctrl.fields.rw     = (state == S_RSTART);
    end

    assign byte_out = state inside {S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= S_IDLE;
            go         <= 1'b0;
            bit_cmd    <= eeprom_pkg::BIT_STOP;
            tx_byte    <= '0;
            done_pulse <= 1'b0;
            nack_flag  <= 1'b0;
        end
        else
        begin
            go         <= 1'b0;
            done_pulse <= 1'b0;
            if (bit_done && byte_out && !ack_ok)
            begin
                // no ack from the memory, abort
                go        <= 1'b1;
                bit_cmd   <= eeprom_pkg::BIT_STOP;
                nack_flag <= 1'b1;
                state     <= S_STOP;
            end
            else
            begin
                case (state)
                    S_IDLE:
                    begin
                        if (start)
                        begin
                            go        <= 1'b1;
                            bit_cmd   <= eeprom_pkg::BIT_START;
                            nack_flag <= 1'b0;
                            state     <= S_START;
                        end
                    end
                    S_START, S_RSTART:
                    begin
                        if (bit_done)
                        begin
                            go      <= 1'b1;
                            bit_cmd <= eeprom_pkg::BIT_WRITE;
                            tx_byte <= ctrl.raw;
                            state   <= (state == S_START) ? S_CTRL_W : S_CTRL_R;
                        end
                    end
                    S_CTRL_W:
                    begin
                        if (bit_done)
                        begin
                            go      <= 1'b1;
                            bit_cmd <= eeprom_pkg::BIT_WRITE;
                            tx_byte <= cmd_addr[eeprom_pkg::DATA_W-1:0];
                            state   <= S_ADDR;
                        end
                    end
                    S_ADDR:
                    begin
                        if (bit_done)
                        begin
                            go <= 1'b1;
                            if (op_read)
                            begin
                                bit_cmd <= eeprom_pkg::BIT_START;  // repeated start
                                state   <= S_RSTART;
                            end
                            else
                            begin
                                bit_cmd <= eeprom_pkg::BIT_WRITE;
                                tx_byte <= cmd_wdata;
                                state   <= S_DATA_W;
                            end
                        end
                    end
                    S_CTRL_R:
                    begin
                        if (bit_done)
                        begin
                            go      <= 1'b1;
                            bit_cmd <= eeprom_pkg::BIT_READ;
                            tx_byte <= MASTER_NACK;
                            state   <= S_DATA_R;
                        end
                    end
                    S_DATA_W, S_DATA_R:
                    begin
                        if (bit_done)
                        begin
                            go      <= 1'b1;
                            bit_cmd <= eeprom_pkg::BIT_STOP;
                            state   <= S_STOP;
                        end
                    end
                    S_STOP:
                    begin
                        if (bit_done)
                        begin
                            done_pulse <= 1'b1;
                            state      <= S_IDLE;
                        end
                    end
                    default:
                        state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_DATA_R && bit_done)
        begin
            read_byte <= rx_byte;
        end
    end

endmodule

/* hdl/eeprom_ctrl_top.sv */
module eeprom_ctrl_top #(
    parameter int CLK_DIV = 2   // scl half period in CLK cycles, 2 or more
) (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            wr,
    input  logic                            rd,
    input  logic [eeprom_pkg::ADDR_W-1:0]   addr,
    input  logic [eeprom_pkg::DATA_W-1:0]   wdata,
    input  logic                            sda_in,
    output logic [eeprom_pkg::DATA_W-1:0]   rdata,
    output logic                            busy,
    output logic                            done,
    output logic                            nack,
    output logic                            scl,
    output logic                            sda_oe
);

    logic                           start;
    logic                           op_read;
    logic [eeprom_pkg::ADDR_W-1:0]  cmd_addr;
    logic [eeprom_pkg::DATA_W-1:0]  cmd_wdata;
    logic                           done_pulse;
    logic [eeprom_pkg::DATA_W-1:0]  read_byte;
    logic                           nack_flag;
    logic                           go;
    logic [1:0]                     bit_cmd;
    logic [eeprom_pkg::DATA_W-1:0]  tx_byte;
    logic                           bit_done;
    logic                           ack_ok;
    logic [eeprom_pkg::DATA_W-1:0]  rx_byte;

    eeprom_cmd_regs i_regs (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .done_pulse (done_pulse),
        .read_byte  (read_byte),
        .nack_flag  (nack_flag),
        .start      (start),
        .op_read    (op_read),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .rdata      (rdata)
    );

    eeprom_sequencer i_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .start      (start),
        .op_read    (op_read),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .bit_done   (bit_done),
        .ack_ok     (ack_ok),
        .rx_byte    (rx_byte),
        .go         (go),
        .bit_cmd    (bit_cmd),
        .tx_byte    (tx_byte),
        .done_pulse (done_pulse),
        .read_byte  (read_byte),
        .nack_flag  (nack_flag)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_bits (
        .CLK      (CLK),
        .RESET    (RESET),
        .go       (go),
        .bit_cmd  (bit_cmd),
        .tx_byte  (tx_byte),
        .sda_in   (sda_in),
        .bit_done (bit_done),
        .ack_ok   (ack_ok),
        .rx_byte  (rx_byte),
        .scl      (scl),
        .sda_oe   (sda_oe)
    );

endmodule

/* verification/eeprom_model.sv */
module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic no_ack,    // withhold every acknowledge
    output logic pull       // 1 pulls sda low
);

    localparam logic [2:0] P_IDLE  = 3'd0;
    localparam logic [2:0] P_CTRL  = 3'd1;
    localparam logic [2:0] P_ADDR  = 3'd2;
    localparam logic [2:0] P_WDATA = 3'd3;
    localparam logic [2:0] P_SEND  = 3'd4;

    logic [7:0]             mem [0:2047];
    logic [2:0]             phase;
    logic [2:0]             phase_next;
    logic [3:0]             bit_cnt;
    logic [7:0]             shreg;
    logic                   ack_pend;
    logic [2:0]             block;
    logic [7:0]             word;
    logic                   scl_q;
    logic                   sda_q;
    eeprom_pkg::ctrl_byte_u cb;

    initial
    begin
        for (int i = 0; i < 2048; i++)
        begin
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;   // whole address in the pattern
        end
        phase    = P_IDLE;
        bit_cnt  = 4'd0;
        ack_pend = 1'b0;
        pull     = 1'b0;
        scl_q    = 1'b1;
        sda_q    = 1'b1;
    end

    // eighth bit of a byte in
    task automatic take_byte();
        cb         = shreg;
        ack_pend   = !no_ack;
        phase_next = P_IDLE;
        if (!no_ack)
        begin
            case (phase)
                P_CTRL:
                begin
                    if (cb.fields.device == eeprom_pkg::DEVICE_CODE)
                    begin
                        block = cb.fields.block;
                        if (cb.fields.rw)
                        begin
                            shreg      = mem[{block, word}];
                            phase_next = P_SEND;
                        end
                        else
                        begin
                            phase_next = P_ADDR;
                        end
                    end
                    else
                    begin
                        ack_pend = 1'b0;    // not our device code
                    end
                end
                P_ADDR:
                begin
                    word       = shreg;
                    phase_next = P_WDATA;
                end
                P_WDATA:
                    mem[{block, word}] = shreg;
                default:
                    ack_pend = 1'b0;
            endcase
        end
    endtask

    task automatic handle_scl_rise();
        if (phase != P_IDLE)
        begin
            if (bit_cnt < 4'd8)
            begin
                if (phase != P_SEND)
                begin
                    shreg = {shreg[6:0], sda};
                end
                bit_cnt = bit_cnt + 4'd1;
                if (bit_cnt == 4'd8 && phase != P_SEND)
                begin
                    take_byte();
                end
            end
            else
            begin
                // ninth clock, single byte reads only
                phase    = (phase == P_SEND) ? P_IDLE : phase_next;
                bit_cnt  = 4'd0;
                ack_pend = 1'b0;
            end
        end
    endtask

    task automatic handle_scl_fall();
        int idx;
        idx = 7 - int'(bit_cnt);
        if (phase == P_SEND && bit_cnt < 4'd8)
        begin
            pull = !shreg[idx[2:0]];
        end
        else if (bit_cnt == 4'd8 && ack_pend)
        begin
            pull = 1'b1;
        end
        else
        begin
            pull = 1'b0;
        end
    endtask

    always @(scl or sda)
    begin
        if (scl !== scl_q)
        begin
            if (scl === 1'b1)
            begin
                handle_scl_rise();
            end
            else if (scl === 1'b0)
            begin
                handle_scl_fall();
            end
        end
        else if (scl === 1'b1 && sda !== sda_q)
        begin
            if (sda === 1'b0)
            begin
                phase    = P_CTRL;  // start or repeated start
                bit_cnt  = 4'd0;
                ack_pend = 1'b0;
            end
            else if (sda === 1'b1)
            begin
                phase   = P_IDLE;   // stop
                bit_cnt = 4'd0;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* verification/eeprom_ctrl_properties.sv */
module eeprom_ctrl_properties (
    input logic       CLK,
    input logic       RESET,
    input logic       busy,
    input logic       done,
    input logic       scl,
    input logic       sda_oe,
    input logic [1:0] bit_cmd
);

    a_done_busy_fell: assert property (@(posedge CLK) disable iff (RESET)
        done |-> !busy && $past(busy))
        else $error("done without busy falling");

    // only start and stop move sda while scl stays high
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_oe)) |->
        (bit_cmd == eeprom_pkg::BIT_START || bit_cmd == eeprom_pkg::BIT_STOP))
        else $error("sda changed while scl high outside start or stop");

    a_reset_state: assert property (@(posedge CLK)
        $fell(RESET) |-> !busy && !done && scl)
        else $error("wrong state after reset");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_properties i_props (
    .CLK     (CLK),
    .RESET   (RESET),
    .busy    (busy),
    .done    (done),
    .scl     (scl),
    .sda_oe  (sda_oe),
    .bit_cmd (bit_cmd)
);

/* verification/tb_eeprom_ctrl.sv */
module tb_eeprom_ctrl;

    localparam int CLK_DIV     = 2;
    localparam int CLK_PERIOD  = 4;
    localparam int SCL_PERIOD  = 2 * CLK_DIV * CLK_PERIOD;
    localparam int N_PAIRS     = 8;
    localparam int N_TRANS     = 2 * N_PAIRS + 11;
    localparam int WAIT_CYCLES = 60 * 2 * CLK_DIV;   // one transaction with margin

    logic                           CLK = 1'b0;
    logic                           RESET;
    logic                           wr;
    logic                           rd;
    logic [eeprom_pkg::ADDR_W-1:0]  addr;
    logic [eeprom_pkg::DATA_W-1:0]  wdata;
    logic                           sda_in;
    logic [eeprom_pkg::DATA_W-1:0]  rdata;
    logic                           busy;
    logic                           done;
    logic                           nack;
    logic                           scl;
    logic                           sda_oe;
    logic                           model_pull;
    logic                           no_ack;
    integer                         seed = 32'h843;
    int                             done_count = 0;

    always #(CLK_PERIOD / 2) CLK = !CLK;

    // open-drain bus, wired AND
    assign sda_in = !(sda_oe || model_pull);

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) i_dut (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .sda_in (sda_in),
        .rdata  (rdata),
        .busy   (busy),
        .done   (done),
        .nack   (nack),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

    eeprom_model i_mem (
        .scl    (scl),
        .sda    (sda_in),
        .no_ack (no_ack),
        .pull   (model_pull)
    );

    always @(posedge CLK)
    begin
        if (!RESET && done)
        begin
            done_count <= done_count + 1;
        end
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(string name, logic [eeprom_pkg::DATA_W-1:0] exp,
                              logic [eeprom_pkg::DATA_W-1:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp)
        begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // called at posedge + 1, returns at posedge + 1
    task automatic send_strobe(logic is_read, logic [eeprom_pkg::ADDR_W-1:0] a,
                               logic [eeprom_pkg::DATA_W-1:0] d);
        wr    = !is_read;
        rd    = is_read;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        while (!done && n < WAIT_CYCLES)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!done)
        begin
            $display("controller gave no done within %0d cycles", WAIT_CYCLES);
            abort_run();
        end
    endtask

    task automatic do_write(logic [eeprom_pkg::ADDR_W-1:0] a, logic [eeprom_pkg::DATA_W-1:0] d);
        send_strobe(1'b0, a, d);
        wait_for_done();
    endtask

    task automatic do_read(logic [eeprom_pkg::ADDR_W-1:0] a);
        send_strobe(1'b1, a, '0);
        wait_for_done();
    endtask

    task automatic test_reset_state();
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);
        check_flag("reset nack", 1'b0, nack);
        check_flag("reset sda_oe", 1'b0, sda_oe);
        check_flag("reset scl", 1'b1, scl);
    endtask

    task automatic test_write_read_back();
        logic [eeprom_pkg::ADDR_W-1:0] a;
        logic [eeprom_pkg::DATA_W-1:0] d;
        for (int i = 0; i < N_PAIRS; i++)
        begin
            a = eeprom_pkg::ADDR_W'($random(seed));
            d = eeprom_pkg::DATA_W'($random(seed));
            do_write(a, d);
            check_flag("write back nack on write", 1'b0, nack);
            do_read(a);
            check_flag("write back nack on read", 1'b0, nack);
            check_byte("write back data", d, rdata);
        end
    endtask

    task automatic test_block_separation();
        logic [7:0]                    low;
        logic [eeprom_pkg::DATA_W-1:0] d;
        low = 8'($random(seed));
        d   = eeprom_pkg::DATA_W'($random(seed));
        do_write({3'd1, low}, d);
        do_write({3'd6, low}, ~d);
        do_read({3'd1, low});
        check_byte("block 1 data", d, rdata);
        do_read({3'd6, low});
        check_byte("block 6 data", ~d, rdata);
    endtask

    task automatic test_missing_ack();
        logic [eeprom_pkg::DATA_W-1:0] prev;
        logic [eeprom_pkg::ADDR_W-1:0] a;
        logic [eeprom_pkg::DATA_W-1:0] d;
        prev   = rdata;
        a      = eeprom_pkg::ADDR_W'($random(seed));
        d      = eeprom_pkg::DATA_W'($random(seed));
        no_ack = 1'b1;
        do_read(a);
        check_flag("missing ack nack", 1'b1, nack);
        check_byte("missing ack rdata kept", prev, rdata);
        no_ack = 1'b0;
        do_write(a, d);
        check_flag("after ack restored nack", 1'b0, nack);
        do_read(a);
        check_flag("after ack restored read nack", 1'b0, nack);
        check_byte("after ack restored data", d, rdata);
    endtask

    task automatic test_busy_protection();
        logic [eeprom_pkg::ADDR_W-1:0] a;
        logic [eeprom_pkg::ADDR_W-1:0] b;
        logic [eeprom_pkg::DATA_W-1:0] va;
        logic [eeprom_pkg::DATA_W-1:0] vb;
        int                            count_before;
        a  = eeprom_pkg::ADDR_W'($random(seed));
        b  = a ^ 11'h400;
        va = eeprom_pkg::DATA_W'($random(seed));
        vb = ~va;
        do_write(b, vb);
        send_strobe(1'b0, a, va);
        count_before = done_count;  // previous done already counted here
        repeat (10) @(posedge CLK);
        #1;
        check_flag("busy during write", 1'b1, busy);
        send_strobe(1'b0, b, va);   // must be dropped
        repeat (5) @(posedge CLK);
        #1;
        send_strobe(1'b1, b, '0);
        wait_for_done();
        check_flag("busy write nack", 1'b0, nack);
        repeat (40) @(posedge CLK);
        #1;
        check_count("done pulses for one request", 1, done_count - count_before);
        check_flag("busy after done", 1'b0, busy);
        do_read(a);
        check_byte("busy accepted data", va, rdata);
        do_read(b);
        check_byte("busy ignored write", vb, rdata);
    endtask

    initial
    begin
        #(2 * N_TRANS * 40 * SCL_PERIOD);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    initial
    begin
        RESET  = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        addr   = '0;
        wdata  = '0;
        no_ack = 1'b0;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        test_reset_state();
        test_write_read_back();
        test_block_separation();
        test_missing_ack();
        test_busy_protection();
        $display("sim passed");
        $finish;
    end

endmodule

/* src.f */
hdl/eeprom_pkg.sv
hdl/eeprom_cmd_regs.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_sequencer.sv
hdl/eeprom_ctrl_top.sv
verification/eeprom_model.sv
verification/eeprom_ctrl_properties.sv
verification/tb_eeprom_ctrl.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_eeprom_ctrl
	./obj_dir/Vtb_eeprom_ctrl > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "sim failed" sim.log; then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir sim.log
